// ==== ring_bridge_pkg.sv ====
package ring_bridge_pkg;

  // bus widths seen by the core
  localparam int ADDR_WIDTH = 64;
  localparam int DATA_WIDTH = 64;

  // queue position below the active flag
  localparam int POS_WIDTH = 31;

  // core FSM states as the core reports them
  typedef enum logic [4:0] {
    WAIT_FOR_START,
    START_BEGIN,
    START_READ_CMD,
    START_READ_CMD_P,
    READ_COND,
    READ_COND_P,
    READ_SRC1,
    READ_SRC1_P,
    READ_SRC0,
    READ_SRC0_P,
    READ_DST,
    WRITE_REG_IP,
    WRITE_DST,
    WRITE_DST_P,
    WRITE_SRC1,
    WRITE_SRC0,
    WRITE_COND,
    ALU_BEGIN,
    FINISH_BEGIN,
    FINISH_END
  } core_state_e;

  // ring message opcodes
  typedef enum logic [7:0] {
    MSG_NONE  = 8'h00,
    MSG_RESET = 8'h01,
    MSG_START = 8'h02,
    MSG_END   = 8'h03
  } cpu_msg_e;

  // all zero means non-active
  typedef struct packed {
    logic                 active;
    logic [POS_WIDTH-1:0] pos;
  } queue_index_t;

  // from the dispatcher ring
  typedef struct packed {
    logic         next_cpu_q;
    logic         bus_busy;
    queue_index_t cpu_index;
    cpu_msg_e     msg;
  } ring_in_t;

  // towards the dispatcher ring
  typedef struct packed {
    logic         next_cpu_e;
    logic         dispatcher_q;
    logic         read_q;
    logic         write_q;
    cpu_msg_e     msg;
    queue_index_t index;
  } ring_out_t;

  // control back to the core
  typedef struct packed {
    logic rst;
    logic ext_rst_e;
    logic next_state;
    logic disp_online;
    logic bus_busy;
  } core_ctl_t;

  // states in which the core reads over the ring
  function automatic logic is_read_state(core_state_e s);
    return s inside {START_READ_CMD, START_READ_CMD_P, READ_COND, READ_COND_P,
                     READ_SRC1, READ_SRC1_P, READ_SRC0, READ_SRC0_P, READ_DST};
  endfunction

  // states in which the core writes over the ring
  function automatic logic is_write_state(core_state_e s);
    return s inside {WRITE_REG_IP, WRITE_DST, WRITE_DST_P, WRITE_SRC1,
                     WRITE_SRC0, WRITE_COND};
  endfunction

endpackage

// ==== reset_seq.sv ====
`timescale 1ns/1ps

module reset_seq (
  input  logic                         clk,
  input  logic                         ext_rst_b,
  input  ring_bridge_pkg::core_state_e state,
  input  logic                         restart,
  output logic                         load,
  output logic                         seq_done,
  output logic                         core_rst,
  output logic                         ext_rst_e,
  output logic                         reset_msg
);

  // five steps, then RUN until the next external reset or a restart
  typedef enum logic [2:0] {
    STEP_CLEAR,
    STEP_SAMPLE,
    STEP_LOAD,
    STEP_PULSE,
    STEP_DONE,
    STEP_RUN
  } step_e;

  step_e step;

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      step      <= STEP_CLEAR;
      seq_done  <= 1'b0;
      core_rst  <= 1'b0;
      ext_rst_e <= 1'b0;
    end else begin
      case (step)
        // grant side clears dispatcher_q and disp_online here
        STEP_CLEAR: step <= STEP_SAMPLE;
        // finished core keeps its index, no reload and no announce
        STEP_SAMPLE: begin
          if (state == ring_bridge_pkg::FINISH_END) begin
            step <= STEP_PULSE;
          end else begin
            step <= STEP_LOAD;
          end
        end
        STEP_LOAD: step <= STEP_PULSE;
        STEP_PULSE: begin
          core_rst  <= 1'b1;
          ext_rst_e <= (state != ring_bridge_pkg::FINISH_END);
          step      <= STEP_DONE;
        end
        STEP_DONE: begin
          core_rst  <= 1'b0;
          ext_rst_e <= 1'b0;
          seq_done  <= 1'b1;
          step      <= STEP_RUN;
        end
        STEP_RUN: begin
          // core parked in FINISH_END, go round again
          if (restart) begin
            seq_done <= 1'b0;
            step     <= STEP_CLEAR;
          end
        end
        default: step <= STEP_CLEAR;
      endcase
    end
  end

  // index load and RESET announce share the load step
  assign load      = (step == STEP_LOAD);
  assign reset_msg = (step == STEP_LOAD);

endmodule

// ==== queue_index.sv ====
`timescale 1ns/1ps

module queue_index (
  input  logic                          clk,
  input  logic                          ext_rst_b,
  input  ring_bridge_pkg::core_state_e  state,
  input  ring_bridge_pkg::ring_in_t     ring_in,
  input  logic                          load,
  input  logic                          granted,
  output ring_bridge_pkg::queue_index_t own_index,
  output logic                          index_match
);

  // index broadcast by the dispatcher or by another processor
  ring_bridge_pkg::queue_index_t bcast;
  logic                          own_zero;
  logic                          bcast_end;
  logic                          bcast_start;
  logic                          pos_below;

  assign bcast       = ring_in.cpu_index;
  assign index_match = (bcast == own_index);
  assign own_zero    = (own_index == '0);
  assign bcast_end   = (ring_in.msg == ring_bridge_pkg::MSG_END);
  assign bcast_start = (ring_in.msg == ring_bridge_pkg::MSG_START);

  // foreign position strictly ahead of ours
  assign pos_below = (bcast.pos < own_index.pos);

  // tracking runs regardless of bus_busy
  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      own_index <= '0;
    end else if (load) begin
      own_index <= bcast;
    end else if (index_match && own_zero &&
                 state == ring_bridge_pkg::START_BEGIN) begin
      // first start from the non-active slot, head of the queue
      own_index.active <= 1'b1;
      own_index.pos    <= '0;
    end else if (!index_match && bcast.active && bcast_end &&
                 own_index.active && pos_below) begin
      // someone ahead of us finished
      own_index.pos <= own_index.pos - 1'b1;
    end else if (!index_match && !bcast.active && bcast_start) begin
      // new thread joined
      // active ones move back, waiting ones move up
      if (own_index.active) begin
        own_index.pos <= own_index.pos + 1'b1;
      end else begin
        own_index.pos <= own_index.pos - 1'b1;
      end
    end else if (!granted && !ring_in.bus_busy) begin
      case (state)
        ring_bridge_pkg::START_BEGIN: own_index.active <= 1'b1;
        // thread done, back to non-active
        ring_bridge_pkg::FINISH_END:  own_index <= '0;
        default: ;
      endcase
    end
  end

endmodule

// ==== grant_ctrl.sv ====
`timescale 1ns/1ps

module grant_ctrl #(
  parameter int unsigned THREAD_HEADER_SPACE = 16
) (
  input  logic                                  clk,
  input  logic                                  ext_rst_b,
  input  ring_bridge_pkg::core_state_e          state,
  input  logic                                  read_q,
  input  logic                                  write_q,
  input  logic [ring_bridge_pkg::ADDR_WIDTH-1:0] addr_in,
  input  logic [ring_bridge_pkg::DATA_WIDTH-1:0] data_in,
  input  ring_bridge_pkg::ring_in_t             ring_in,
  input  ring_bridge_pkg::queue_index_t         own_index,
  input  logic                                  index_match,
  input  logic                                  seq_done,
  input  logic                                  reset_msg,
  output logic                                  granted,
  output logic                                  restart,
  output ring_bridge_pkg::ring_out_t            ring_out,
  output logic                                  next_state,
  output logic                                  disp_online,
  output logic [ring_bridge_pkg::ADDR_WIDTH-1:0] base_addr,
  output logic [ring_bridge_pkg::ADDR_WIDTH-1:0] base_addr_data
);

  logic                                   read_class;
  logic                                   write_class;
  logic                                   any_req;
  logic                                   release_now;
  logic                                   dispatcher_q_q;
  logic                                   reset_tail;
  ring_bridge_pkg::cpu_msg_e              msg_q;
  ring_bridge_pkg::queue_index_t          index_q;
  logic [ring_bridge_pkg::ADDR_WIDTH-1:0] hdr_space;

  assign hdr_space   = ring_bridge_pkg::ADDR_WIDTH'(THREAD_HEADER_SPACE);
  assign read_class  = ring_bridge_pkg::is_read_state(state);
  assign write_class = ring_bridge_pkg::is_write_state(state);
  assign any_req     = read_q | write_q;

  // dispatcher picked us and the ring is free
  assign granted = seq_done & ring_in.next_cpu_q & index_match & ~ring_in.bus_busy;

  // core stopped using the bus, hand the ring back
  assign release_now = disp_online & ~any_req & ~ring_in.bus_busy;

  // parked in FINISH_END with nothing granted, rerun the reset steps
  assign restart = seq_done & ~granted & ~ring_in.bus_busy &
                   (state == ring_bridge_pkg::FINISH_END);

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      msg_q          <= ring_bridge_pkg::MSG_NONE;
      index_q        <= '0;
      next_state     <= 1'b0;
      disp_online    <= 1'b0;
      dispatcher_q_q <= 1'b0;
      reset_tail     <= 1'b0;
    end else begin
      // msg, index and next_state are single-cycle
      msg_q      <= ring_bridge_pkg::MSG_NONE;
      index_q    <= '0;
      next_state <= 1'b0;
      // two cycles after RESET the dispatcher request goes up
      reset_tail <= (msg_q == ring_bridge_pkg::MSG_RESET);
      if (reset_msg) begin
        msg_q   <= ring_bridge_pkg::MSG_RESET;
        index_q <= ring_in.cpu_index;
      end
      if (!seq_done) begin
        disp_online    <= 1'b0;
        dispatcher_q_q <= reset_tail;
      end else if (granted) begin
        disp_online  <= 1'b1;
        case (state)
          ring_bridge_pkg::WAIT_FOR_START: begin
            msg_q      <= ring_bridge_pkg::MSG_START;
            index_q    <= own_index;
            next_state <= 1'b1;
          end
          ring_bridge_pkg::FINISH_BEGIN: begin
            msg_q      <= ring_bridge_pkg::MSG_END;
            index_q    <= own_index;
            next_state <= 1'b1;
          end
          default: ;
        endcase
        if (read_class || write_class) begin
          dispatcher_q_q <= 1'b1;
        end
      end else if (!ring_in.bus_busy) begin
        if (release_now) begin
          disp_online  <= 1'b0;
        end
        // keep asking while the core has bus work
        // idle core drops the request
        if (read_class || write_class) begin
          dispatcher_q_q <= 1'b1;
        end else if (state == ring_bridge_pkg::WAIT_FOR_START) begin
          dispatcher_q_q <= 1'b0;
        end
      end
    end
  end

  // thread base addresses, taken on the start grant only
  always_ff @(posedge clk) begin
    if (granted && state == ring_bridge_pkg::WAIT_FOR_START) begin
      base_addr <= addr_in + hdr_space;
      // no separate data area, data follows the header
      if (data_in == '0) begin
        base_addr_data <= addr_in + hdr_space;
      end else begin
        base_addr_data <= ring_bridge_pkg::ADDR_WIDTH'(data_in) + hdr_space;
      end
    end
  end

  // requests pass straight through while we own the ring
  always_comb begin
    // grant answer lasts exactly as long as we hold the ring
    ring_out.next_cpu_e   = disp_online;
    ring_out.dispatcher_q = dispatcher_q_q;
    ring_out.read_q       = disp_online & read_class & read_q;
    ring_out.write_q      = disp_online & write_class & write_q;
    ring_out.msg          = msg_q;
    ring_out.index        = index_q;
  end

endmodule

// ==== ring_bridge.sv ====
`timescale 1ns/1ps

module ring_bridge #(
  parameter int unsigned THREAD_HEADER_SPACE = 16
) (
  input  logic                                  clk,
  input  logic                                  ext_rst_b,
  input  ring_bridge_pkg::core_state_e          state,
  input  logic                                  read_q,
  input  logic                                  write_q,
  input  logic [ring_bridge_pkg::ADDR_WIDTH-1:0] addr_in,
  input  logic [ring_bridge_pkg::DATA_WIDTH-1:0] data_in,
  input  ring_bridge_pkg::ring_in_t             ring_in,
  output ring_bridge_pkg::ring_out_t            ring_out,
  output ring_bridge_pkg::core_ctl_t            core_ctl,
  output logic [ring_bridge_pkg::ADDR_WIDTH-1:0] base_addr,
  output logic [ring_bridge_pkg::ADDR_WIDTH-1:0] base_addr_data
);

  // sequencer side
  logic load;
  logic seq_done;
  logic core_rst;
  logic ext_rst_e;
  logic reset_msg;

  // grant side
  logic granted;
  logic restart;
  logic next_state;
  logic disp_online;

  // own queue slot
  ring_bridge_pkg::queue_index_t own_index;
  logic                          index_match;

  reset_seq u_reset_seq (
    .clk       (clk),
    .ext_rst_b (ext_rst_b),
    .state     (state),
    .restart   (restart),
    .load      (load),
    .seq_done  (seq_done),
    .core_rst  (core_rst),
    .ext_rst_e (ext_rst_e),
    .reset_msg (reset_msg)
  );

  queue_index u_queue_index (
    .clk         (clk),
    .ext_rst_b   (ext_rst_b),
    .state       (state),
    .ring_in     (ring_in),
    .load        (load),
    .granted     (granted),
    .own_index   (own_index),
    .index_match (index_match)
  );

  grant_ctrl #(
    .THREAD_HEADER_SPACE (THREAD_HEADER_SPACE)
  ) u_grant_ctrl (
    .clk            (clk),
    .ext_rst_b      (ext_rst_b),
    .state          (state),
    .read_q         (read_q),
    .write_q        (write_q),
    .addr_in        (addr_in),
    .data_in        (data_in),
    .ring_in        (ring_in),
    .own_index      (own_index),
    .index_match    (index_match),
    .seq_done       (seq_done),
    .reset_msg      (reset_msg),
    .granted        (granted),
    .restart        (restart),
    .ring_out       (ring_out),
    .next_state     (next_state),
    .disp_online    (disp_online),
    .base_addr      (base_addr),
    .base_addr_data (base_addr_data)
  );

  // core sees the bus busy while it is held in its own reset
  assign core_ctl = '{rst:         core_rst,
                      ext_rst_e:   ext_rst_e,
                      next_state:  next_state,
                      disp_online: disp_online,
                      bus_busy:    ext_rst_e};

endmodule

// ==== ring_bridge_assert.sv ====
`timescale 1ns/1ps

module ring_bridge_assert (
  input logic                       clk,
  input logic                       ext_rst_b,
  input ring_bridge_pkg::ring_out_t ring_out,
  input ring_bridge_pkg::core_ctl_t core_ctl
);

  // read by the testbench top at the end of the run
  int fail_count = 0;

  // core reset is a one-cycle pulse
  rst_single_cycle: assert property (@(posedge clk) disable iff (ext_rst_b)
    core_ctl.rst |=> !core_ctl.rst)
    else begin
      fail_count++;
      $error("core rst held for two cycles");
    end

  // next_state only with an own START or END
  next_state_msg: assert property (@(posedge clk) disable iff (ext_rst_b)
    core_ctl.next_state |-> (ring_out.msg == ring_bridge_pkg::MSG_START ||
                             ring_out.msg == ring_bridge_pkg::MSG_END))
    else begin
      fail_count++;
      $error("next_state without START or END on the ring");
    end

  // no bus request without the ring
  req_needs_online: assert property (@(posedge clk) disable iff (ext_rst_b)
    !core_ctl.disp_online |-> !(ring_out.read_q || ring_out.write_q))
    else begin
      fail_count++;
      $error("ring request while disp_online is low");
    end

endmodule

// ==== ring_bridge_checker.sv ====
`timescale 1ns/1ps

module ring_bridge_checker #(
  parameter int unsigned HDR = 16
) (
  input  logic                          clk,
  input  logic                          ext_rst_b,
  input  ring_bridge_pkg::core_state_e  state,
  input  logic                          read_q,
  input  logic                          write_q,
  input  logic [63:0]                   addr_in,
  input  logic [63:0]                   data_in,
  input  ring_bridge_pkg::ring_in_t     ring_in,
  input  ring_bridge_pkg::ring_out_t    ring_out,
  input  ring_bridge_pkg::core_ctl_t    core_ctl,
  input  logic [63:0]                   base_addr,
  input  logic [63:0]                   base_addr_data,
  input  int                            test_id,
  output ring_bridge_pkg::queue_index_t model_index,
  output int                            error_count,
  output int                            check_count
);

  ring_bridge_pkg::queue_index_t nidx;
  ring_bridge_pkg::queue_index_t m_out_idx;
  ring_bridge_pkg::cpu_msg_e     m_msg;
  logic                          m_next;
  logic                          m_disp;
  logic                          m_dq;
  logic                          seq_ok;
  logic                          match;
  logic                          grant;
  logic                          rd_class;
  logic                          wr_class;
  logic                          base_valid = 1'b0;
  logic [63:0]                   m_base;
  logic [63:0]                   m_base_data;
  int                            edge_no;
  int                            cur_test = 0;
  int                            test_checks = 0;
  int                            test_errs = 0;
  string test_name [6] = '{"", "reset sequence", "start grant", "queue tracking",
                           "request gating", "back-pressure"};

  initial begin
    error_count = 0;
    check_count = 0;
  end

  task automatic expect_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
    check_count++;
    test_checks++;
    if (got !== exp) begin
      error_count++;
      test_errs++;
      $display("Fail at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  // sampled at the rising edge, before the DUT registers update
  always @(posedge clk) begin
    if (test_id != cur_test) begin
      if (cur_test != 0) begin
        $display("test %0d %s: %0d checks, %0d errors", cur_test, test_name[cur_test],
                 test_checks, test_errs);
      end
      cur_test    = test_id;
      test_checks = 0;
      test_errs   = 0;
    end
    if (ext_rst_b) begin
      edge_no     = 0;
      m_disp      = 1'b0;
      m_dq        = 1'b0;
      m_msg       = ring_bridge_pkg::MSG_NONE;
      m_out_idx   = '0;
      m_next      = 1'b0;
      model_index = '0;
    end else begin
      edge_no  = edge_no + 1;
      rd_class = state >= ring_bridge_pkg::START_READ_CMD && state <= ring_bridge_pkg::READ_DST;
      wr_class = state >= ring_bridge_pkg::WRITE_REG_IP && state <= ring_bridge_pkg::WRITE_COND;
      // outputs seen now were decided at the previous edge
      expect_eq(ring_out.read_q, m_disp & rd_class & read_q, "ring read_q");
      expect_eq(ring_out.write_q, m_disp & wr_class & write_q, "ring write_q");
      expect_eq(ring_out.next_cpu_e, m_disp, "next_cpu_e");
      expect_eq(core_ctl.disp_online, m_disp, "disp_online");
      expect_eq(ring_out.msg, m_msg, "msg");
      expect_eq(ring_out.index, m_out_idx, "msg index");
      expect_eq(core_ctl.next_state, m_next, "next_state");
      // core reset pulse belongs to edge 4
      expect_eq(core_ctl.rst, edge_no == 5, "core rst");
      expect_eq(core_ctl.ext_rst_e, edge_no == 5, "ext_rst_e");
      expect_eq(core_ctl.bus_busy, edge_no == 5, "core bus_busy");
      // low through the sequence, up once it ends and after bus work
      if (edge_no <= 5) begin
        expect_eq(ring_out.dispatcher_q, 1'b0, "dispatcher_q during reset");
      end else if (edge_no == 6 || m_dq) begin
        expect_eq(ring_out.dispatcher_q, 1'b1, "dispatcher_q");
      end
      if (base_valid) begin
        expect_eq(base_addr, m_base, "base_addr");
        expect_eq(base_addr_data, m_base_data, "base_addr_data");
      end

      // grants only once the sequence is over
      seq_ok = edge_no >= 6;
      match  = (ring_in.cpu_index == model_index);
      grant  = seq_ok && ring_in.next_cpu_q && match && !ring_in.bus_busy;

      m_msg     = ring_bridge_pkg::MSG_NONE;
      m_out_idx = '0;
      m_next    = 1'b0;
      if (edge_no == 3) begin
        m_msg     = ring_bridge_pkg::MSG_RESET;
        m_out_idx = ring_in.cpu_index;
      end
      if (!seq_ok) begin
        m_disp = 1'b0;
      end else if (grant) begin
        m_disp = 1'b1;
        if (state == ring_bridge_pkg::WAIT_FOR_START) begin
          m_msg       = ring_bridge_pkg::MSG_START;
          m_out_idx   = model_index;
          m_next      = 1'b1;
          base_valid  = 1'b1;
          m_base      = addr_in + 64'(HDR);
          m_base_data = (data_in == '0) ? addr_in + 64'(HDR) : data_in + 64'(HDR);
        end else if (state == ring_bridge_pkg::FINISH_BEGIN) begin
          m_msg     = ring_bridge_pkg::MSG_END;
          m_out_idx = model_index;
          m_next    = 1'b1;
        end
      end else if (!ring_in.bus_busy && !(read_q || write_q)) begin
        m_disp = 1'b0;
      end

      // read or write state on a free ring raises the dispatcher request
      m_dq = seq_ok && !ring_in.bus_busy && (rd_class || wr_class);

      // queue index, highest priority first
      nidx = model_index;
      if (edge_no == 3) begin
        nidx = ring_in.cpu_index;
      end else if (match && model_index == '0 && state == ring_bridge_pkg::START_BEGIN) begin
        nidx.active = 1'b1;
        nidx.pos    = '0;
      end else if (!match && ring_in.cpu_index.active && ring_in.msg == ring_bridge_pkg::MSG_END &&
                   model_index.active && ring_in.cpu_index.pos < model_index.pos) begin
        nidx.pos = model_index.pos - 1;
      end else if (!match && !ring_in.cpu_index.active &&
                   ring_in.msg == ring_bridge_pkg::MSG_START) begin
        nidx.pos = model_index.active ? model_index.pos + 1 : model_index.pos - 1;
      end else if (!grant && !ring_in.bus_busy && state == ring_bridge_pkg::START_BEGIN) begin
        nidx.active = 1'b1;
      end
      model_index = nidx;
    end
  end

endmodule

// ==== tb_ring_bridge.sv ====
`timescale 1ns/1ps

module tb_ring_bridge;

  localparam int unsigned HDR_SPACE = 16;
  localparam int PERIOD = 40;
  // reset 21, start 102, tracking 125, gating 68, back-pressure 40, tail 4
  localparam int TOTAL_CYCLES = 360;
  localparam int TIMEOUT_NS = TOTAL_CYCLES * PERIOD + 4000;

  logic                                   clk;
  logic                                   ext_rst_b;
  ring_bridge_pkg::core_state_e           state;
  logic                                   read_q;
  logic                                   write_q;
  logic [ring_bridge_pkg::ADDR_WIDTH-1:0] addr_in;
  logic [ring_bridge_pkg::DATA_WIDTH-1:0] data_in;
  ring_bridge_pkg::ring_in_t              ring_in;
  ring_bridge_pkg::ring_out_t             ring_out;
  ring_bridge_pkg::core_ctl_t             core_ctl;
  logic [ring_bridge_pkg::ADDR_WIDTH-1:0] base_addr;
  logic [ring_bridge_pkg::ADDR_WIDTH-1:0] base_addr_data;
  ring_bridge_pkg::queue_index_t          model_index;
  int                                     error_count;
  int                                     check_count;
  int                                     test_id;
  int                                     tb_errs;
  int                                     n;
  int                                     i;
  logic [15:0]                            lfsr;
  logic [63:0]                            r;

  ring_bridge #(
    .THREAD_HEADER_SPACE (HDR_SPACE)
  ) u_ring_bridge (
    .clk            (clk),
    .ext_rst_b      (ext_rst_b),
    .state          (state),
    .read_q         (read_q),
    .write_q        (write_q),
    .addr_in        (addr_in),
    .data_in        (data_in),
    .ring_in        (ring_in),
    .ring_out       (ring_out),
    .core_ctl       (core_ctl),
    .base_addr      (base_addr),
    .base_addr_data (base_addr_data)
  );

  ring_bridge_checker #(
    .HDR (HDR_SPACE)
  ) u_checker (
    .clk            (clk),
    .ext_rst_b      (ext_rst_b),
    .state          (state),
    .read_q         (read_q),
    .write_q        (write_q),
    .addr_in        (addr_in),
    .data_in        (data_in),
    .ring_in        (ring_in),
    .ring_out       (ring_out),
    .core_ctl       (core_ctl),
    .base_addr      (base_addr),
    .base_addr_data (base_addr_data),
    .test_id        (test_id),
    .model_index    (model_index),
    .error_count    (error_count),
    .check_count    (check_count)
  );

  bind ring_bridge ring_bridge_assert u_ring_bridge_assert (
    .clk       (clk),
    .ext_rst_b (ext_rst_b),
    .ring_out  (ring_out),
    .core_ctl  (core_ctl)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // one lfsr step per bit taken
  task automatic take_bits(input int nbits, output logic [63:0] v);
    v = '0;
    for (int k = 0; k < nbits; k++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[62:0], lfsr[0]};
    end
  endtask

  // dispatcher offers our own index, optionally behind a busy ring
  task automatic offer_grant(input ring_bridge_pkg::core_state_e st, input int busy_cycles);
    int w;
    state              = st;
    ring_in.msg        = ring_bridge_pkg::MSG_NONE;
    ring_in.next_cpu_q = 1'b1;
    ring_in.cpu_index  = model_index;
    ring_in.bus_busy   = (busy_cycles > 0);
    repeat (busy_cycles) @(negedge clk);
    ring_in.bus_busy = 1'b0;
    w = 0;
    do begin
      @(negedge clk);
      w++;
    end while (!core_ctl.disp_online && w < 8);
    ring_in.next_cpu_q = 1'b0;
    if (!core_ctl.disp_online) begin
      tb_errs++;
      $display("grant in state %s was never taken", st.name());
    end
  endtask

  // core drops both requests, ring must come back
  task automatic wait_release();
    int w;
    read_q  = 1'b0;
    write_q = 1'b0;
    w = 0;
    while (ring_out.next_cpu_e && w < 8) begin
      @(negedge clk);
      w++;
    end
    if (ring_out.next_cpu_e) begin
      tb_errs++;
      $display("next_cpu_e stayed high after the core dropped its requests");
    end
  endtask

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: run did not finish within %0d ns", TIMEOUT_NS);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    lfsr                        = 16'd48;
    tb_errs                     = 0;
    test_id                     = 1;
    ext_rst_b                   = 1'b1;
    state                       = ring_bridge_pkg::WAIT_FOR_START;
    read_q                      = 1'b0;
    write_q                     = 1'b0;
    addr_in                     = '0;
    data_in                     = '0;
    ring_in                     = '0;
    ring_in.msg                 = ring_bridge_pkg::MSG_NONE;
    // index handed out by the ring at load time
    ring_in.cpu_index.active    = 1'b1;
    ring_in.cpu_index.pos       = 31'd4;
    repeat (5) @(negedge clk);
    ext_rst_b = 1'b0;
    n = 0;
    while (!ring_out.dispatcher_q && n < 12) begin
      @(negedge clk);
      n++;
    end
    if (!ring_out.dispatcher_q) begin
      tb_errs++;
      $display("dispatcher_q did not rise after the reset sequence");
    end
    repeat (2) @(negedge clk);

    // start grants, first one with data_in zero
    test_id = 2;
    for (i = 0; i < 6; i++) begin
      take_bits(64, r);
      addr_in = r;
      take_bits(64, r);
      data_in = (i == 0) ? '0 : r;
      offer_grant(ring_bridge_pkg::WAIT_FOR_START, 0);
      wait_release();
    end

    // foreign broadcasts, own emission every eighth cycle
    test_id = 3;
    for (i = 0; i < 40; i++) begin
      @(negedge clk);
      take_bits(2, r);
      ring_in.msg = (r == 1) ? ring_bridge_pkg::MSG_START :
                    (r >= 2) ? ring_bridge_pkg::MSG_END : ring_bridge_pkg::MSG_NONE;
      take_bits(1, r);
      ring_in.cpu_index.active = r[0];
      take_bits(3, r);
      ring_in.cpu_index.pos = 31'(r);
      if (i % 8 == 7) begin
        @(negedge clk);
        offer_grant((i % 16 == 7) ? ring_bridge_pkg::WAIT_FOR_START :
                    ring_bridge_pkg::FINISH_BEGIN, 0);
        wait_release();
      end
    end
    ring_in.msg = ring_bridge_pkg::MSG_NONE;

    // random states and requests, FINISH_END left out
    test_id = 4;
    for (i = 0; i < 60; i++) begin
      @(negedge clk);
      take_bits(5, r);
      state = ring_bridge_pkg::core_state_e'(r % 19);
      take_bits(2, r);
      read_q  = r[0];
      write_q = r[1];
      take_bits(3, r);
      ring_in.next_cpu_q = (r < 2);
      take_bits(3, r);
      ring_in.bus_busy = (r == 7);
      take_bits(64, r);
      addr_in = r;
      take_bits(64, r);
      data_in = r;
      ring_in.cpu_index = model_index;
    end
    @(negedge clk);
    state              = ring_bridge_pkg::WAIT_FOR_START;
    ring_in.next_cpu_q = 1'b0;
    ring_in.bus_busy   = 1'b0;
    wait_release();

    // grant held off by a busy ring
    test_id = 5;
    @(negedge clk);
    offer_grant(ring_bridge_pkg::WAIT_FOR_START, 4);
    wait_release();
    @(negedge clk);
    offer_grant(ring_bridge_pkg::FINISH_BEGIN, 3);
    wait_release();

    test_id = 0;
    repeat (2) @(negedge clk);
    $display("checks %0d, value errors %0d, handshake errors %0d, assertion failures %0d",
             check_count, error_count, tb_errs, u_ring_bridge.u_ring_bridge_assert.fail_count);
    if (error_count == 0 && tb_errs == 0 &&
        u_ring_bridge.u_ring_bridge_assert.fail_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
ring_bridge_pkg.sv
reset_seq.sv
queue_index.sv
grant_ctrl.sv
ring_bridge.sv
ring_bridge_assert.sv
ring_bridge_checker.sv
tb_ring_bridge.sv

// ==== Bender.yml ====
package:
  name: ring_bridge

sources:
  - ring_bridge_pkg.sv
  - reset_seq.sv
  - queue_index.sv
  - grant_ctrl.sv
  - ring_bridge.sv
  - target: simulation
    files:
      - ring_bridge_assert.sv
      - ring_bridge_checker.sv
      - tb_ring_bridge.sv
